// ==== hdl/bus_pkg.sv ====
// ############################
// bus word types, request and response structs
// and the arbiter state encoding shared by the
// hosts, the fabric and the targets
// ############################
package bus_pkg;

	// byte address as seen by every host
	typedef logic [31:0] addr_t;

	// one bus word
	typedef logic [31:0] data_t;

	// request from a host, forwarded unchanged by the arbiter
	// rd and we are single-cycle strobes
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic we;
		logic rd;
	} bus_req_t;

	// response from a target, ready is a one-cycle pulse
	typedef struct packed {
		data_t rdata;
		logic ready;
	} bus_rsp_t;

	// grant holder of the two-host arbiter
	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,
		ARB_HOST0 = 2'd1,
		ARB_HOST1 = 2'd2
	} arb_state_t;

endpackage

// ==== hdl/mmap_pkg.sv ====
// ############################
// memory map of the fabric
// region and page codes, GPIO register offsets,
// GPIO widths and the unmapped read pattern
// ############################
package mmap_pkg;

	// top nibble of the byte address
	typedef logic [3:0] region_t;

	localparam region_t REGION_MAIN = 4'h2;
	localparam region_t REGION_MMIO = 4'h9;

	// address bits 27:24 inside MMIO
	typedef logic [3:0] page_t;

	localparam page_t PAGE_SCRATCH = 4'h0;
	localparam page_t PAGE_GPIO = 4'h1;

	// word offsets inside the GPIO page
	localparam logic [1:0] GPIO_LED_WORD = 2'd0;
	localparam logic [1:0] GPIO_IN_WORD = 2'd1;

	// returned for any address nobody decodes
	localparam logic [31:0] UNMAPPED_DATA = 32'hdead_beef;

	// board I/O widths
	localparam int LED_W = 4;
	localparam int SW_W = 2;
	localparam int BTN_W = 2;

endpackage

// ==== hdl/bus_arbiter.sv ====
// ############################
// two-host bus arbiter
// fixed priority from idle, host 0 wins a tie,
// the grant is held until the owner drops req
// ############################
`timescale 1ns/1ps

module bus_arbiter (
	input logic clk_mem,
	input logic rst,

	input logic host0_req,
	output logic host0_gnt,
	input bus_pkg::bus_req_t host0_cmd,
	output bus_pkg::bus_rsp_t host0_rsp,

	input logic host1_req,
	output logic host1_gnt,
	input bus_pkg::bus_req_t host1_cmd,
	output bus_pkg::bus_rsp_t host1_rsp,

	output bus_pkg::bus_req_t bus_cmd,
	input bus_pkg::bus_rsp_t bus_rsp
);
	import bus_pkg::*;

	arb_state_t state;
	arb_state_t state_next;

	// release always passes through idle for one cycle
	always_comb begin
		state_next = state;
		case (state)
			ARB_IDLE: begin
				if (host0_req)
					state_next = ARB_HOST0;
				else if (host1_req)
					state_next = ARB_HOST1;
			end
			ARB_HOST0: begin
				if (!host0_req)
					state_next = ARB_IDLE;
			end
			ARB_HOST1: begin
				if (!host1_req)
					state_next = ARB_IDLE;
			end
			default: state_next = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk_mem) begin
		if (rst)
			state <= ARB_IDLE;
		else
			state <= state_next;
	end

	assign host0_gnt = (state == ARB_HOST0);
	assign host1_gnt = (state == ARB_HOST1);

	// forward the owner, an idle bus carries zeros
	always_comb begin
		bus_cmd = '0;
		host0_rsp = '0;
		host1_rsp = '0;
		case (state)
			ARB_HOST0: begin
				bus_cmd = host0_cmd;
				host0_rsp = bus_rsp;
			end
			ARB_HOST1: begin
				bus_cmd = host1_cmd;
				host1_rsp = bus_rsp;
			end
			default: bus_cmd = '0;
		endcase
	end

	a_gnt_exclusive: assert property (@(posedge clk_mem) disable iff (rst)
		!(host0_gnt && host1_gnt))
		else $error("arbiter: both hosts granted");

	// a host strobes only while it owns the bus
	a_strobe_granted: assert property (@(posedge clk_mem) disable iff (rst)
		((host0_cmd.rd || host0_cmd.we) |-> host0_gnt) and
		((host1_cmd.rd || host1_cmd.we) |-> host1_gnt))
		else $error("arbiter: strobe from a host without grant");

endmodule

// ==== hdl/addr_decoder.sv ====
// ############################
// two-level address decoder
// region picks main memory or MMIO, the MMIO page
// picks scratch RAM or GPIO, anything else gets
// the unmapped pattern one cycle later
// ############################
`timescale 1ns/1ps

module addr_decoder (
	input logic clk_mem,
	input logic rst,

	input bus_pkg::bus_req_t bus_cmd,
	output bus_pkg::bus_rsp_t bus_rsp,

	output bus_pkg::bus_req_t main_cmd,
	input bus_pkg::bus_rsp_t main_rsp,

	output bus_pkg::bus_req_t scratch_cmd,
	input bus_pkg::bus_rsp_t scratch_rsp,

	output bus_pkg::bus_req_t gpio_cmd,
	input bus_pkg::bus_rsp_t gpio_rsp
);
	import bus_pkg::*;
	import mmap_pkg::*;

	region_t region;
	page_t page;
	logic sel_main;
	logic sel_scratch;
	logic sel_gpio;
	logic sel_none;
	logic unm_ready;

	assign region = bus_cmd.addr[31:28];
	assign page = bus_cmd.addr[27:24];

	assign sel_main = (region == REGION_MAIN);
	assign sel_scratch = (region == REGION_MMIO) && (page == PAGE_SCRATCH);
	assign sel_gpio = (region == REGION_MMIO) && (page == PAGE_GPIO);
	assign sel_none = !(sel_main || sel_scratch || sel_gpio);

	// address and data fan out, only strobes are steered
	always_comb begin
		main_cmd = bus_cmd;
		main_cmd.rd = bus_cmd.rd & sel_main;
		main_cmd.we = bus_cmd.we & sel_main;
		scratch_cmd = bus_cmd;
		scratch_cmd.rd = bus_cmd.rd & sel_scratch;
		scratch_cmd.we = bus_cmd.we & sel_scratch;
		gpio_cmd = bus_cmd;
		gpio_cmd.rd = bus_cmd.rd & sel_gpio;
		gpio_cmd.we = bus_cmd.we & sel_gpio;
	end

	// unmapped responder, writes are dropped
	always_ff @(posedge clk_mem) begin
		if (rst)
			unm_ready <= 1'b0;
		else
			unm_ready <= sel_none && (bus_cmd.rd || bus_cmd.we);
	end

	always_comb begin
		bus_rsp.ready = main_rsp.ready | scratch_rsp.ready | gpio_rsp.ready | unm_ready;
		if (main_rsp.ready)
			bus_rsp.rdata = main_rsp.rdata;
		else if (scratch_rsp.ready)
			bus_rsp.rdata = scratch_rsp.rdata;
		else if (gpio_rsp.ready)
			bus_rsp.rdata = gpio_rsp.rdata;
		else if (unm_ready)
			bus_rsp.rdata = UNMAPPED_DATA;
		else
			bus_rsp.rdata = '0;
	end

	a_one_ready: assert property (@(posedge clk_mem) disable iff (rst)
		$onehot0({main_rsp.ready, scratch_rsp.ready, gpio_rsp.ready, unm_ready}))
		else $error("decoder: more than one target answered");

endmodule

// ==== hdl/word_ram.sv ====
// ############################
// single-port word RAM
// 2^AW words, registered read data and
// a ready pulse one cycle after each strobe
// ############################
`timescale 1ns/1ps

module word_ram #(
	parameter int AW = 10
) (
	input logic clk_mem,
	input logic rst,

	input bus_pkg::bus_req_t cmd,
	output bus_pkg::bus_rsp_t rsp
);
	import bus_pkg::*;

	data_t mem [2**AW];
	logic [AW-1:0] word_idx;
	data_t rdata_q;
	logic ready_q;

	// byte address to word index, upper bits alias
	assign word_idx = cmd.addr[AW+1:2];

	always_ff @(posedge clk_mem) begin
		if (cmd.we)
			mem[word_idx] <= cmd.wdata;
	end

	always_ff @(posedge clk_mem) begin
		if (cmd.rd)
			rdata_q <= mem[word_idx];
	end

	always_ff @(posedge clk_mem) begin
		if (rst)
			ready_q <= 1'b0;
		else
			ready_q <= cmd.rd | cmd.we;
	end

	assign rsp = '{rdata: rdata_q, ready: ready_q};

	a_no_rd_we: assert property (@(posedge clk_mem) disable iff (rst)
		!(cmd.rd && cmd.we))
		else $error("word_ram: rd and we in the same cycle");

endmodule

// ==== hdl/gpio_regs.sv ====
// ############################
// GPIO registers
// LED output register and a read-only input word
// with switches above buttons, both inputs pass
// a two-flop synchroniser
// ############################
`timescale 1ns/1ps

module gpio_regs (
	input logic clk_mem,
	input logic rst,

	input bus_pkg::bus_req_t cmd,
	output bus_pkg::bus_rsp_t rsp,

	input logic [mmap_pkg::SW_W-1:0] sw,
	input logic [mmap_pkg::BTN_W-1:0] btn,
	output logic [mmap_pkg::LED_W-1:0] led
);
	import bus_pkg::*;
	import mmap_pkg::*;

	logic [SW_W+BTN_W-1:0] in_meta;
	logic [SW_W+BTN_W-1:0] in_sync;
	logic [1:0] word;
	data_t rdata_q;
	logic ready_q;

	assign word = cmd.addr[3:2];

	// asynchronous board inputs
	always_ff @(posedge clk_mem) begin
		in_meta <= {sw, btn};
		in_sync <= in_meta;
	end

	always_ff @(posedge clk_mem) begin
		if (rst)
			led <= '0;
		else if (cmd.we && word == GPIO_LED_WORD)
			led <= cmd.wdata[LED_W-1:0];
	end

	always_ff @(posedge clk_mem) begin
		if (cmd.rd) begin
			case (word)
				GPIO_LED_WORD: rdata_q <= data_t'(led);
				GPIO_IN_WORD: rdata_q <= data_t'(in_sync);
				default: rdata_q <= '0;
			endcase
		end
	end

	// every strobe is answered, unknown offsets too
	always_ff @(posedge clk_mem) begin
		if (rst)
			ready_q <= 1'b0;
		else
			ready_q <= cmd.rd | cmd.we;
	end

	assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// ==== hdl/quasi_bus_top.sv ====
// ############################
// two-host bus fabric top level
// arbiter, address decoder, main and scratch
// RAMs and the GPIO block on clk_mem
// ############################
`timescale 1ns/1ps

module quasi_bus_top #(
	parameter int MAIN_AW = 12,
	parameter int SCRATCH_AW = 10
) (
	input logic clk_mem,
	input logic rst,

	// host 0, CPU side
	input logic host0_req,
	output logic host0_gnt,
	input bus_pkg::bus_req_t host0_cmd,
	output bus_pkg::bus_rsp_t host0_rsp,

	// host 1, serial boot side
	input logic host1_req,
	output logic host1_gnt,
	input bus_pkg::bus_req_t host1_cmd,
	output bus_pkg::bus_rsp_t host1_rsp,

	input logic [mmap_pkg::SW_W-1:0] sw,
	input logic [mmap_pkg::BTN_W-1:0] btn,
	output logic [mmap_pkg::LED_W-1:0] led
);
	import bus_pkg::*;

	// shared bus after arbitration
	bus_req_t bus_cmd;
	bus_rsp_t bus_rsp;

	// per-target links
	bus_req_t main_cmd;
	bus_rsp_t main_rsp;
	bus_req_t scratch_cmd;
	bus_rsp_t scratch_rsp;
	bus_req_t gpio_cmd;
	bus_rsp_t gpio_rsp;

	bus_arbiter u_bus_arbiter (
		.clk_mem(clk_mem),
		.rst(rst),
		.host0_req(host0_req),
		.host0_gnt(host0_gnt),
		.host0_cmd(host0_cmd),
		.host0_rsp(host0_rsp),
		.host1_req(host1_req),
		.host1_gnt(host1_gnt),
		.host1_cmd(host1_cmd),
		.host1_rsp(host1_rsp),
		.bus_cmd(bus_cmd),
		.bus_rsp(bus_rsp)
	);

	addr_decoder u_addr_decoder (
		.clk_mem(clk_mem),
		.rst(rst),
		.bus_cmd(bus_cmd),
		.bus_rsp(bus_rsp),
		.main_cmd(main_cmd),
		.main_rsp(main_rsp),
		.scratch_cmd(scratch_cmd),
		.scratch_rsp(scratch_rsp),
		.gpio_cmd(gpio_cmd),
		.gpio_rsp(gpio_rsp)
	);

	word_ram #(
		.AW(MAIN_AW)
	) u_main_ram (
		.clk_mem(clk_mem),
		.rst(rst),
		.cmd(main_cmd),
		.rsp(main_rsp)
	);

	word_ram #(
		.AW(SCRATCH_AW)
	) u_scratch_ram (
		.clk_mem(clk_mem),
		.rst(rst),
		.cmd(scratch_cmd),
		.rsp(scratch_rsp)
	);

	gpio_regs u_gpio_regs (
		.clk_mem(clk_mem),
		.rst(rst),
		.cmd(gpio_cmd),
		.rsp(gpio_rsp),
		.sw(sw),
		.btn(btn),
		.led(led)
	);

endmodule

// ==== bench/clock_gen.sv ====
// ############################
// testbench clock and reset
// 20 ns clk_mem, rst high for 5 cycles
// ############################
`timescale 1ns/1ps

module clock_gen (
	output logic clk_mem,
	output logic rst
);

	initial begin
		clk_mem = 1'b0;
		forever #10 clk_mem = ~clk_mem;
	end

	// release just after the fifth rising edge
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk_mem);
		#2 rst = 1'b0;
	end

endmodule

// ==== bench/tb_quasi_bus.sv ====
// ############################
// testbench for the two-host bus fabric
// directed tests for reset, RAMs, unmapped
// reads, GPIO and arbitration, then random
// traffic checked against a word model
// ############################
`timescale 1ns/1ps

module tb_quasi_bus;
	import bus_pkg::*;
	import mmap_pkg::*;

	localparam int MAIN_AW = 12;
	localparam int SCRATCH_AW = 10;
	localparam int WAIT_LIMIT = 50;

	logic clk_mem;
	logic rst;
	logic host0_req;
	logic host0_gnt;
	bus_req_t host0_cmd;
	bus_rsp_t host0_rsp;
	logic host1_req;
	logic host1_gnt;
	bus_req_t host1_cmd;
	bus_rsp_t host1_rsp;
	logic [SW_W-1:0] sw;
	logic [BTN_W-1:0] btn;
	logic [LED_W-1:0] led;

	int errors;
	int tests;
	int failed_tests;
	logic [31:0] lcg_state;

	// word models and the indices written into them
	data_t main_model [2**MAIN_AW];
	data_t scratch_model [2**SCRATCH_AW];
	int main_used [$];
	int scratch_used [$];

	clock_gen u_clock_gen (
		.clk_mem(clk_mem),
		.rst(rst)
	);

	quasi_bus_top #(
		.MAIN_AW(MAIN_AW),
		.SCRATCH_AW(SCRATCH_AW)
	) u_quasi_bus_top (
		.clk_mem(clk_mem),
		.rst(rst),
		.host0_req(host0_req),
		.host0_gnt(host0_gnt),
		.host0_cmd(host0_cmd),
		.host0_rsp(host0_rsp),
		.host1_req(host1_req),
		.host1_gnt(host1_gnt),
		.host1_cmd(host1_cmd),
		.host1_rsp(host1_rsp),
		.sw(sw),
		.btn(btn),
		.led(led)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// word index placed into a main memory address, junk fills the aliased bits
	function automatic addr_t main_addr(input int idx, input logic [31:0] junk);
		addr_t a;
		a = {REGION_MAIN, junk[27:0]};
		a[MAIN_AW+1:2] = idx[MAIN_AW-1:0];
		a[1:0] = 2'b00;
		return a;
	endfunction

	function automatic addr_t scratch_addr(input int idx, input logic [31:0] junk);
		addr_t a;
		a = {REGION_MMIO, PAGE_SCRATCH, junk[23:0]};
		a[SCRATCH_AW+1:2] = idx[SCRATCH_AW-1:0];
		a[1:0] = 2'b00;
		return a;
	endfunction

	function automatic logic gnt_of(input int h);
		return (h == 0) ? host0_gnt : host1_gnt;
	endfunction

	function automatic bus_rsp_t rsp_of(input int h);
		return (h == 0) ? host0_rsp : host1_rsp;
	endfunction

	task automatic next_cycle();
		@(posedge clk_mem);
		#2;
	endtask

	task automatic check_value(input string name, input data_t expected, input data_t actual);
		assert (actual === expected)
		else begin
			$display("ERR %0t ns %s expected %h actual %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic set_req(input int h, input logic value);
		if (h == 0)
			host0_req = value;
		else
			host1_req = value;
	endtask

	task automatic drive_cmd(input int h, input bus_req_t cmd);
		if (h == 0)
			host0_cmd = cmd;
		else
			host1_cmd = cmd;
	endtask

	task automatic wait_grant(input int h, input logic level);
		int n;
		n = 0;
		while (gnt_of(h) !== level && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (gnt_of(h) !== level)
			report_problem($sformatf("host %0d grant did not go to %0d in %0d cycles",
				h, level, WAIT_LIMIT));
	endtask

	task automatic acquire(input int h);
		set_req(h, 1'b1);
		next_cycle();
		wait_grant(h, 1'b1);
	endtask

	task automatic release_bus(input int h);
		set_req(h, 1'b0);
		next_cycle();
		wait_grant(h, 1'b0);
	endtask

	// one-cycle strobe, ready expected on the next cycle and only there
	task automatic do_access(input int h, input logic is_write, input addr_t addr,
			input data_t wdata, output data_t rdata);
		bus_req_t cmd;
		bus_rsp_t rsp;
		bus_rsp_t other;
		int n;
		cmd = '{addr: addr, wdata: wdata, we: is_write, rd: !is_write};
		drive_cmd(h, cmd);
		next_cycle();
		cmd.we = 1'b0;
		cmd.rd = 1'b0;
		drive_cmd(h, cmd);
		rsp = rsp_of(h);
		if (rsp.ready !== 1'b1) begin
			report_problem($sformatf("host %0d got no ready one cycle after the strobe", h));
			n = 0;
			while (rsp.ready !== 1'b1 && n < WAIT_LIMIT) begin
				next_cycle();
				rsp = rsp_of(h);
				n++;
			end
			if (rsp.ready !== 1'b1)
				report_problem($sformatf("host %0d never got ready", h));
		end
		rdata = rsp.rdata;
		other = rsp_of(1 - h);
		check_value($sformatf("host%0d_rsp.ready", 1 - h), 32'd0, data_t'(other.ready));
		next_cycle();
		rsp = rsp_of(h);
		check_value($sformatf("host%0d_rsp.ready after pulse", h), 32'd0, data_t'(rsp.ready));
	endtask

	task automatic write_word(input int h, input addr_t addr, input data_t data);
		data_t unused;
		do_access(h, 1'b1, addr, data, unused);
	endtask

	task automatic read_check(input int h, input addr_t addr, input data_t expected);
		data_t got;
		do_access(h, 1'b0, addr, '0, got);
		check_value($sformatf("host%0d_rsp.rdata @%h", h, addr), expected, got);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_reset();
		int e0;
		int n;
		e0 = errors;
		n = 0;
		while (rst !== 1'b0 && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (rst !== 1'b0)
			report_problem("reset was never released");
		check_value("host0_gnt", 32'd0, data_t'(host0_gnt));
		check_value("host1_gnt", 32'd0, data_t'(host1_gnt));
		check_value("host0_rsp.ready", 32'd0, data_t'(host0_rsp.ready));
		check_value("host1_rsp.ready", 32'd0, data_t'(host1_rsp.ready));
		check_value("led", 32'd0, data_t'(led));
		finish_test("reset", e0);
	endtask

	task automatic test_main();
		int e0;
		data_t vals [4];
		e0 = errors;
		acquire(0);
		for (int i = 0; i < 4; i++) begin
			vals[i] = next_random();
			write_word(0, main_addr(i * 37 + 5, 0), vals[i]);
		end
		for (int i = 0; i < 4; i++)
			read_check(0, main_addr(i * 37 + 5, 0), vals[i]);
		// one memory size higher lands on the same word
		vals[0] = next_random();
		write_word(0, main_addr(5, 32'd1 << (MAIN_AW + 2)), vals[0]);
		read_check(0, main_addr(5, 0), vals[0]);
		release_bus(0);
		finish_test("main memory", e0);
	endtask

	task automatic test_scratch();
		int e0;
		data_t svals [4];
		data_t mvals [4];
		e0 = errors;
		acquire(0);
		for (int i = 0; i < 4; i++) begin
			svals[i] = next_random();
			mvals[i] = next_random();
			write_word(0, scratch_addr(i, 0), svals[i]);
			write_word(0, main_addr(i, 0), mvals[i]);
		end
		for (int i = 0; i < 4; i++) begin
			read_check(0, scratch_addr(i, 0), svals[i]);
			read_check(0, main_addr(i, 0), mvals[i]);
		end
		read_check(0, 32'h5000_0040, UNMAPPED_DATA);
		release_bus(0);
		finish_test("scratch and unmapped", e0);
	endtask

	task automatic test_gpio();
		int e0;
		e0 = errors;
		acquire(0);
		write_word(0, 32'h9100_0000, 32'h1234_567a);
		check_value("led", 32'h0000_000a, data_t'(led));
		read_check(0, 32'h9100_0000, 32'h0000_000a);
		sw = 2'b10;
		btn = 2'b01;
		// two synchroniser stages plus margin
		repeat (3) next_cycle();
		read_check(0, 32'h9100_0004, 32'h0000_0009);
		release_bus(0);
		finish_test("gpio", e0);
	endtask

	task automatic test_arbitration();
		int e0;
		data_t val;
		e0 = errors;
		val = next_random();
		host0_req = 1'b1;
		host1_req = 1'b1;
		next_cycle();
		wait_grant(0, 1'b1);
		check_value("host1_gnt", 32'd0, data_t'(host1_gnt));
		write_word(0, main_addr(100, 0), val);
		release_bus(0);
		wait_grant(1, 1'b1);
		check_value("host0_gnt", 32'd0, data_t'(host0_gnt));
		read_check(1, main_addr(100, 0), val);
		release_bus(1);
		finish_test("arbitration", e0);
	endtask

	task automatic test_random();
		int e0;
		int h;
		int idx;
		logic [31:0] r;
		data_t data;
		e0 = errors;
		for (int i = 0; i < 32; i++) begin
			h = i % 2;
			r = next_random();
			data = next_random();
			acquire(h);
			if (r[31]) begin
				idx = int'(r[SCRATCH_AW-1:0]);
				write_word(h, scratch_addr(idx, next_random()), data);
				scratch_model[idx] = data;
				scratch_used.push_back(idx);
				read_check(h, scratch_addr(idx, next_random()), scratch_model[idx]);
			end else begin
				idx = int'(r[MAIN_AW-1:0]);
				write_word(h, main_addr(idx, next_random()), data);
				main_model[idx] = data;
				main_used.push_back(idx);
				read_check(h, main_addr(idx, next_random()), main_model[idx]);
			end
			release_bus(h);
		end
		// every word written above must still hold its last value
		acquire(0);
		for (int k = 0; k < main_used.size(); k++) begin
			idx = main_used[k];
			read_check(0, main_addr(idx, next_random()), main_model[idx]);
		end
		for (int k = 0; k < scratch_used.size(); k++) begin
			idx = scratch_used[k];
			read_check(0, scratch_addr(idx, next_random()), scratch_model[idx]);
		end
		release_bus(0);
		finish_test("random traffic", e0);
	endtask

	initial begin
		host0_req = 1'b0;
		host0_cmd = '0;
		host1_req = 1'b0;
		host1_cmd = '0;
		sw = '0;
		btn = '0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		lcg_state = 32'hd81b_d858;
		test_reset();
		test_main();
		test_scratch();
		test_gpio();
		test_arbitration();
		test_random();
		$display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== quasi_bus.f ====
hdl/bus_pkg.sv
hdl/mmap_pkg.sv
hdl/bus_arbiter.sv
hdl/addr_decoder.sv
hdl/word_ram.sv
hdl/gpio_regs.sv
hdl/quasi_bus_top.sv
bench/clock_gen.sv
bench/tb_quasi_bus.sv
